/* flist.f */
hdl/core_pkg.sv
hdl/alu_unit.sv
hdl/branch_unit.sv
hdl/fetch_decode.sv
hdl/operand_stage.sv
hdl/exec_retire.sv
hdl/mini_core.sv
test/tb_clock_gen.sv
test/mini_core_props.sv
test/tb_mini_core.sv

/* hdl/alu_unit.sv */
`timescale 1ns/1ns

module alu_unit (
    input  core_pkg::exe_entry_t exe_entry_i,
    output core_pkg::xlen_t      alu_result_o,
    output core_pkg::fwd_t       exe_fwd_o
);
    import core_pkg::*;

    xlen_t op1;
    xlen_t op2;

    assign op1 = exe_entry_i.op1;
    assign op2 = exe_entry_i.op2;

    always_comb begin
        case (exe_entry_i.ctrl.alu_op)
            ALU_ADD: alu_result_o = op1 + op2;
            ALU_SUB: alu_result_o = op1 - op2;
            ALU_AND: alu_result_o = op1 & op2;
            ALU_OR:  alu_result_o = op1 | op2;
            ALU_XOR: alu_result_o = op1 ^ op2;
            default: alu_result_o = op1 + op2;
        endcase
    end

    // jal link comes from the retire record instead
    assign exe_fwd_o.valid = exe_entry_i.valid && exe_entry_i.ctrl.rd_wen
                             && !exe_entry_i.ctrl.is_jal;
    assign exe_fwd_o.rd    = exe_entry_i.ctrl.rd;
    assign exe_fwd_o.wdata = alu_result_o;

endmodule

/* hdl/branch_unit.sv */
`timescale 1ns/1ns

module branch_unit (
    input  core_pkg::exe_entry_t exe_entry_i,
    output core_pkg::br_res_t    br_res_o
);
    import core_pkg::*;

    logic  ops_equal;
    logic  cond_met;
    addr_t taken_target;
    addr_t seq_target;

    // op2 holds rs2 for branches, use_imm is never set there
    assign ops_equal = (exe_entry_i.op1 == exe_entry_i.op2);

    always_comb begin
        if (exe_entry_i.ctrl.br_ne) begin
            cond_met = !ops_equal;
        end else begin
            cond_met = ops_equal;
        end
    end

    // imm is already B or J form, picked in decode
    assign taken_target = exe_entry_i.pc + exe_entry_i.imm;
    assign seq_target   = exe_entry_i.pc + INST_BYTES;

    always_comb begin
        if (exe_entry_i.ctrl.is_jal) begin
            br_res_o.taken = 1'b1;
        end else if (exe_entry_i.ctrl.is_br) begin
            br_res_o.taken = cond_met;
        end else begin
            br_res_o.taken = 1'b0;
        end
    end

    // fall-through address when not taken
    assign br_res_o.target = br_res_o.taken ? taken_target : seq_target;

endmodule

/* hdl/core_pkg.sv */
package core_pkg;

    //////////////////////////////////////////////////////////////////////
    // basic widths
    //////////////////////////////////////////////////////////////////////

    typedef logic [31:0] xlen_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  alu_op_t;

    localparam addr_t INST_BYTES = 32'd4;

    // major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_XOR = 3'd4;

    //////////////////////////////////////////////////////////////////////
    // pipeline records
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic  valid;
        addr_t pc;
        inst_t inst;
    } fetch_t;

    typedef struct packed {
        logic      rd_wen;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      use_imm;
        alu_op_t   alu_op;
        logic      is_br;
        logic      br_ne;
        logic      is_jal;
        logic      illegal;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        ctrl_t ctrl;
        xlen_t imm;
    } op_entry_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        ctrl_t ctrl;
        xlen_t op1;
        xlen_t op2;
        xlen_t imm;
    } exe_entry_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        xlen_t     wdata;
    } fwd_t;

    typedef struct packed {
        logic  taken;
        addr_t target;
    } br_res_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } redirect_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        logic  is_br;
        logic  is_jmp;
        logic  taken;
        addr_t target;
    } brinfo_t;

    typedef struct packed {
        logic      valid;
        addr_t     pc;
        logic      rd_wen;
        reg_addr_t rd;
        xlen_t     wdata;
        logic      illegal;
    } retire_t;

endpackage

/* hdl/exec_retire.sv */
`timescale 1ns/1ns

module exec_retire (
    input  logic                 clk,
    input  logic                 reset_i,
    input  core_pkg::exe_entry_t exe_entry_i,
    input  core_pkg::xlen_t      alu_result_i,
    input  core_pkg::br_res_t    br_res_i,
    output logic                 flush_now_o,
    output core_pkg::redirect_t  redirect_o,
    output core_pkg::brinfo_t    brinfo_o,
    output core_pkg::retire_t    retire_o
);
    import core_pkg::*;

    xlen_t wdata;
    logic  is_cti;

    // fetch always runs sequential, any taken cti mispredicts
    assign flush_now_o = exe_entry_i.valid && br_res_i.taken;

    assign is_cti = exe_entry_i.ctrl.is_br || exe_entry_i.ctrl.is_jal;

    // link value for jal
    assign wdata = exe_entry_i.ctrl.is_jal ? (exe_entry_i.pc + INST_BYTES) : alu_result_i;

    //////////////////////////////////////////////////////////////////////
    // retire record
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i) begin
            retire_o.valid <= 1'b0;
        end else begin
            retire_o.valid   <= exe_entry_i.valid;
            retire_o.pc      <= exe_entry_i.pc;
            retire_o.rd_wen  <= exe_entry_i.ctrl.rd_wen;
            retire_o.rd      <= exe_entry_i.ctrl.rd;
            retire_o.wdata   <= wdata;
            retire_o.illegal <= exe_entry_i.ctrl.illegal;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // redirect and branch report
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i) begin
            redirect_o.valid <= 1'b0;
        end else begin
            redirect_o.valid <= flush_now_o;
            redirect_o.addr  <= br_res_i.target;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            brinfo_o.valid <= 1'b0;
        end else begin
            brinfo_o.valid  <= exe_entry_i.valid && is_cti;
            brinfo_o.pc     <= exe_entry_i.pc;
            brinfo_o.is_br  <= exe_entry_i.ctrl.is_br;
            brinfo_o.is_jmp <= exe_entry_i.ctrl.is_jal;
            brinfo_o.taken  <= br_res_i.taken;
            brinfo_o.target <= br_res_i.target;
        end
    end

endmodule

/* hdl/fetch_decode.sv */
`timescale 1ns/1ns

module fetch_decode (
    input  logic                clk,
    input  logic                reset_i,
    input  core_pkg::fetch_t    fetch_i,
    input  logic                flush_now_i,
    input  logic                flush_last_i,
    output core_pkg::op_entry_t op_entry_o
);
    import core_pkg::*;

    fetch_t     dec_q;
    ctrl_t      dec_ctrl;
    xlen_t      dec_imm;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm_i;
    xlen_t      imm_b;
    xlen_t      imm_j;

    // decode register, dropped during a redirect and the cycle after it
    always_ff @(posedge clk) begin
        if (reset_i || flush_now_i || flush_last_i) begin
            dec_q.valid <= 1'b0;
        end else begin
            dec_q <= fetch_i;
        end
    end

    assign opcode = dec_q.inst[6:0];
    assign funct3 = dec_q.inst[14:12];
    assign funct7 = dec_q.inst[31:25];

    //////////////////////////////////////////////////////////////////////
    // instruction decoder
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        dec_ctrl        = '0;
        dec_ctrl.rd     = dec_q.inst[11:7];
        dec_ctrl.rs1    = dec_q.inst[19:15];
        dec_ctrl.rs2    = dec_q.inst[24:20];
        dec_ctrl.alu_op = ALU_ADD;
        case (opcode)
            OPC_OP: begin
                dec_ctrl.rd_wen = 1'b1;
                if (funct7 == F7_BASE && funct3 == F3_ADD) begin
                    dec_ctrl.alu_op = ALU_ADD;
                end else if (funct7 == F7_SUB && funct3 == F3_ADD) begin
                    dec_ctrl.alu_op = ALU_SUB;
                end else if (funct7 == F7_BASE && funct3 == F3_AND) begin
                    dec_ctrl.alu_op = ALU_AND;
                end else if (funct7 == F7_BASE && funct3 == F3_OR) begin
                    dec_ctrl.alu_op = ALU_OR;
                end else if (funct7 == F7_BASE && funct3 == F3_XOR) begin
                    dec_ctrl.alu_op = ALU_XOR;
                end else begin
                    dec_ctrl.illegal = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                // addi only
                dec_ctrl.rd_wen  = 1'b1;
                dec_ctrl.use_imm = 1'b1;
                dec_ctrl.illegal = (funct3 != F3_ADD);
            end
            OPC_BRANCH: begin
                dec_ctrl.is_br   = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
                dec_ctrl.br_ne   = (funct3 == F3_BNE);
                dec_ctrl.illegal = !dec_ctrl.is_br;
            end
            OPC_JAL: begin
                dec_ctrl.rd_wen = 1'b1;
                dec_ctrl.is_jal = 1'b1;
            end
            default: dec_ctrl.illegal = 1'b1;
        endcase
        // x0 and illegal encodings never write
        if (dec_ctrl.illegal || dec_ctrl.rd == '0) begin
            dec_ctrl.rd_wen = 1'b0;
        end
    end

    // immediates, sign extended
    assign imm_i = {{20{dec_q.inst[31]}}, dec_q.inst[31:20]};
    assign imm_b = {{19{dec_q.inst[31]}}, dec_q.inst[31], dec_q.inst[7],
                    dec_q.inst[30:25], dec_q.inst[11:8], 1'b0};
    assign imm_j = {{11{dec_q.inst[31]}}, dec_q.inst[31], dec_q.inst[19:12],
                    dec_q.inst[20], dec_q.inst[30:21], 1'b0};

    always_comb begin
        case (opcode)
            OPC_BRANCH: dec_imm = imm_b;
            OPC_JAL:    dec_imm = imm_j;
            default:    dec_imm = imm_i;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_now_i) begin
            op_entry_o.valid <= 1'b0;
        end else begin
            op_entry_o.valid <= dec_q.valid;
            op_entry_o.pc    <= dec_q.pc;
            op_entry_o.ctrl  <= dec_ctrl;
            op_entry_o.imm   <= dec_imm;
        end
    end

endmodule

/* hdl/mini_core.sv */
`timescale 1ns/1ns

module mini_core (
    input  logic                clk,
    input  logic                reset_i,
    input  core_pkg::fetch_t    fetch_i,
    output core_pkg::redirect_t redirect_o,
    output core_pkg::brinfo_t   brinfo_o,
    output core_pkg::retire_t   retire_o
);
    import core_pkg::*;

    op_entry_t  op_entry;
    exe_entry_t exe_entry;
    xlen_t      alu_result;
    fwd_t       exe_fwd;
    br_res_t    br_res;
    logic       flush_now;

    //////////////////////////////////////////////////////////////////////
    // decode and operand select
    //////////////////////////////////////////////////////////////////////

    fetch_decode i_fetch_decode (
        .clk          (clk),
        .reset_i      (reset_i),
        .fetch_i      (fetch_i),
        .flush_now_i  (flush_now),
        .flush_last_i (redirect_o.valid),
        .op_entry_o   (op_entry)
    );

    // retire record doubles as write port and second bypass
    operand_stage i_operand_stage (
        .clk         (clk),
        .reset_i     (reset_i),
        .op_entry_i  (op_entry),
        .flush_now_i (flush_now),
        .exe_fwd_i   (exe_fwd),
        .retire_i    (retire_o),
        .exe_entry_o (exe_entry)
    );

    //////////////////////////////////////////////////////////////////////
    // execute and retire
    //////////////////////////////////////////////////////////////////////

    alu_unit i_alu_unit (
        .exe_entry_i  (exe_entry),
        .alu_result_o (alu_result),
        .exe_fwd_o    (exe_fwd)
    );

    branch_unit i_branch_unit (
        .exe_entry_i (exe_entry),
        .br_res_o    (br_res)
    );

    exec_retire i_exec_retire (
        .clk          (clk),
        .reset_i      (reset_i),
        .exe_entry_i  (exe_entry),
        .alu_result_i (alu_result),
        .br_res_i     (br_res),
        .flush_now_o  (flush_now),
        .redirect_o   (redirect_o),
        .brinfo_o     (brinfo_o),
        .retire_o     (retire_o)
    );

endmodule

/* hdl/operand_stage.sv */
`timescale 1ns/1ns

module operand_stage (
    input  logic                 clk,
    input  logic                 reset_i,
    input  core_pkg::op_entry_t  op_entry_i,
    input  logic                 flush_now_i,
    input  core_pkg::fwd_t       exe_fwd_i,
    input  core_pkg::retire_t    retire_i,
    output core_pkg::exe_entry_t exe_entry_o
);
    import core_pkg::*;

    xlen_t     regs [1:31];
    reg_addr_t rs1;
    reg_addr_t rs2;
    xlen_t     rs1_rf;
    xlen_t     rs2_rf;
    xlen_t     rs1_val;
    xlen_t     rs2_val;

    // youngest producer wins
    function automatic xlen_t pick_src(
        input reg_addr_t ra,
        input xlen_t     rf_val,
        input fwd_t      exe_src,
        input retire_t   ret_src
    );
        if (exe_src.valid && exe_src.rd == ra) begin
            return exe_src.wdata;
        end else if (ret_src.valid && ret_src.rd_wen && ret_src.rd == ra) begin
            return ret_src.wdata;
        end
        return rf_val;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // register file
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (retire_i.valid && retire_i.rd_wen) begin
            regs[retire_i.rd] <= retire_i.wdata;
        end
    end

    assign rs1 = op_entry_i.ctrl.rs1;
    assign rs2 = op_entry_i.ctrl.rs2;

    // x0 reads as zero
    assign rs1_rf = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_rf = (rs2 == '0) ? '0 : regs[rs2];

    assign rs1_val = (rs1 == '0) ? '0 : pick_src(rs1, rs1_rf, exe_fwd_i, retire_i);
    assign rs2_val = (rs2 == '0) ? '0 : pick_src(rs2, rs2_rf, exe_fwd_i, retire_i);

    // execute pipeline register
    always_ff @(posedge clk) begin
        if (reset_i || flush_now_i) begin
            exe_entry_o.valid <= 1'b0;
        end else begin
            exe_entry_o.valid <= op_entry_i.valid;
            exe_entry_o.pc    <= op_entry_i.pc;
            exe_entry_o.ctrl  <= op_entry_i.ctrl;
            exe_entry_o.op1   <= rs1_val;
            exe_entry_o.op2   <= op_entry_i.ctrl.use_imm ? op_entry_i.imm : rs2_val;
            exe_entry_o.imm   <= op_entry_i.imm;
        end
    end

endmodule

/* test/mini_core_props.sv */
`timescale 1ns/1ns

module mini_core_props (
    input logic                clk,
    input logic                reset_i,
    input core_pkg::redirect_t redirect_i,
    input core_pkg::brinfo_t   brinfo_i,
    input core_pkg::retire_t   retire_i
);

    // execute is cleared by the redirect, so no second one can follow
    redirect_gap: assert property (@(posedge clk) disable iff (reset_i)
        redirect_i.valid |=> !redirect_i.valid)
        else $error("redirect asserted in two consecutive cycles");

    brinfo_with_retire: assert property (@(posedge clk) disable iff (reset_i)
        brinfo_i.valid |-> retire_i.valid)
        else $error("brinfo valid without retire valid");

    no_x0_write: assert property (@(posedge clk) disable iff (reset_i)
        (retire_i.valid && retire_i.rd_wen) |-> (retire_i.rd != 5'd0))
        else $error("retire writes x0");

    // mid-cycle sample, outputs have settled from the reset edge
    quiet_in_reset: assert property (@(negedge clk)
        reset_i |-> !(retire_i.valid || redirect_i.valid || brinfo_i.valid))
        else $error("output valid high during reset");

endmodule

bind mini_core mini_core_props i_props (
    .clk        (clk),
    .reset_i    (reset_i),
    .redirect_i (redirect_o),
    .brinfo_i   (brinfo_o),
    .retire_i   (retire_o)
);

/* test/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);
    localparam int HALF_PERIOD_NS = 10;
    localparam int RESET_CYCLES   = 3;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD_NS clk_o = ~clk_o;
    end

    // reset seen by the first three rising edges
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

/* test/tb_mini_core.sv */
`timescale 1ns/1ns

module tb_mini_core;
    import core_pkg::*;

    localparam int RETIRE_TIMEOUT = 40;
    localparam int QUIET_CYCLES   = 20;

    typedef struct packed {
        addr_t     pc;
        logic      rd_wen;
        reg_addr_t rd;
        xlen_t     wdata;
        logic      illegal;
        logic      cti;
        logic      is_jmp;
        logic      taken;
        addr_t     target;
    } exp_t;

    logic      clk;
    logic      reset_i;
    fetch_t    fetch_i;
    redirect_t redirect_o;
    brinfo_t   brinfo_o;
    retire_t   retire_o;

    addr_t       prog_pc[$];
    inst_t       prog_inst[$];
    exp_t        exp_q[$];
    logic [31:0] rand_state = 32'd80299;
    logic        run_done = 1'b0;
    int          mismatch_count = 0;
    int          timeout_count = 0;

    tb_clock_gen i_clock_gen (
        .clk_o   (clk),
        .reset_o (reset_i)
    );

    mini_core i_dut (
        .clk        (clk),
        .reset_i    (reset_i),
        .fetch_i    (fetch_i),
        .redirect_o (redirect_o),
        .brinfo_o   (brinfo_o),
        .retire_o   (retire_o)
    );

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // instruction encoding and tables
    //////////////////////////////////////////////////////////////////////

    function automatic inst_t rtype_word(input logic [6:0] f7, input logic [2:0] f3,
                                         input reg_addr_t rd, input reg_addr_t rs1,
                                         input reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic inst_t addi_word(input reg_addr_t rd, input reg_addr_t rs1,
                                        input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic inst_t branch_word(input logic [2:0] f3, input reg_addr_t rs1,
                                          input reg_addr_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic inst_t jal_word(input reg_addr_t rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic put_inst(input addr_t pc, input inst_t inst);
        prog_pc.push_back(pc);
        prog_inst.push_back(inst);
    endtask

    task automatic expect_row(input addr_t pc, input logic wen, input reg_addr_t rd,
                              input xlen_t wdata, input logic ill, input logic cti,
                              input logic jmp, input logic taken, input addr_t target);
        exp_t e;
        e.pc      = pc;
        e.rd_wen  = wen;
        e.rd      = rd;
        e.wdata   = wdata;
        e.illegal = ill;
        e.cti     = cti;
        e.is_jmp  = jmp;
        e.taken   = taken;
        e.target  = target;
        exp_q.push_back(e);
    endtask

    task automatic load_tables();
        put_inst(32'h00, addi_word(5'd1, 5'd0, 12'd5));
        put_inst(32'h04, addi_word(5'd2, 5'd0, 12'hffd));
        put_inst(32'h08, rtype_word(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
        put_inst(32'h0c, rtype_word(7'h20, 3'b000, 5'd4, 5'd3, 5'd1));
        put_inst(32'h10, rtype_word(7'h00, 3'b111, 5'd5, 5'd4, 5'd1));
        put_inst(32'h14, rtype_word(7'h00, 3'b110, 5'd6, 5'd5, 5'd2));
        put_inst(32'h18, rtype_word(7'h00, 3'b100, 5'd7, 5'd6, 5'd1));
        put_inst(32'h1c, branch_word(3'b000, 5'd4, 5'd2, 13'd12));
        put_inst(32'h20, addi_word(5'd8, 5'd0, 12'd99));
        put_inst(32'h24, addi_word(5'd9, 5'd0, 12'd77));
        put_inst(32'h28, branch_word(3'b001, 5'd1, 5'd1, 13'd8));
        put_inst(32'h2c, branch_word(3'b001, 5'd3, 5'd0, 13'd12));
        put_inst(32'h30, addi_word(5'd10, 5'd0, 12'd1));
        put_inst(32'h34, addi_word(5'd11, 5'd0, 12'd1));
        put_inst(32'h38, jal_word(5'd12, 21'd16));
        put_inst(32'h3c, addi_word(5'd13, 5'd0, 12'd55));
        put_inst(32'h40, addi_word(5'd13, 5'd0, 12'd56));
        put_inst(32'h44, addi_word(5'd13, 5'd0, 12'd57));
        put_inst(32'h48, addi_word(5'd14, 5'd12, 12'd4));
        put_inst(32'h4c, 32'hffff_ffff);
        put_inst(32'h50, addi_word(5'd0, 5'd0, 12'd123));
        put_inst(32'h54, rtype_word(7'h00, 3'b000, 5'd15, 5'd0, 5'd14));
        put_inst(32'h58, addi_word(5'd16, 5'd0, 12'h800));
        put_inst(32'h5c, rtype_word(7'h20, 3'b111, 5'd17, 5'd1, 5'd2));
        put_inst(32'h60, rtype_word(7'h20, 3'b000, 5'd18, 5'd16, 5'd1));
        put_inst(32'h64, addi_word(5'd19, 5'd18, 12'h7ff));

        // pc, wen, rd, wdata, illegal, cti, jmp, taken, target
        expect_row(32'h00, 1, 5'd1, 32'h0000_0005, 0, 0, 0, 0, 32'h0);
        expect_row(32'h04, 1, 5'd2, 32'hffff_fffd, 0, 0, 0, 0, 32'h0);
        expect_row(32'h08, 1, 5'd3, 32'h0000_0002, 0, 0, 0, 0, 32'h0);
        expect_row(32'h0c, 1, 5'd4, 32'hffff_fffd, 0, 0, 0, 0, 32'h0);
        expect_row(32'h10, 1, 5'd5, 32'h0000_0005, 0, 0, 0, 0, 32'h0);
        expect_row(32'h14, 1, 5'd6, 32'hffff_fffd, 0, 0, 0, 0, 32'h0);
        expect_row(32'h18, 1, 5'd7, 32'hffff_fff8, 0, 0, 0, 0, 32'h0);
        expect_row(32'h1c, 0, 5'd0, 32'h0, 0, 1, 0, 1, 32'h28);
        expect_row(32'h28, 0, 5'd0, 32'h0, 0, 1, 0, 0, 32'h2c);
        expect_row(32'h2c, 0, 5'd0, 32'h0, 0, 1, 0, 1, 32'h38);
        expect_row(32'h38, 1, 5'd12, 32'h0000_003c, 0, 1, 1, 1, 32'h48);
        expect_row(32'h48, 1, 5'd14, 32'h0000_0040, 0, 0, 0, 0, 32'h0);
        expect_row(32'h4c, 0, 5'd0, 32'h0, 1, 0, 0, 0, 32'h0);
        expect_row(32'h50, 0, 5'd0, 32'h0, 0, 0, 0, 0, 32'h0);
        expect_row(32'h54, 1, 5'd15, 32'h0000_0040, 0, 0, 0, 0, 32'h0);
        expect_row(32'h58, 1, 5'd16, 32'hffff_f800, 0, 0, 0, 0, 32'h0);
        expect_row(32'h5c, 0, 5'd0, 32'h0, 1, 0, 0, 0, 32'h0);
        expect_row(32'h60, 1, 5'd18, 32'hffff_f7fb, 0, 0, 0, 0, 32'h0);
        expect_row(32'h64, 1, 5'd19, 32'hffff_fffa, 0, 0, 0, 0, 32'h0);
    endtask

    function automatic int lookup_inst(input addr_t pc);
        for (int i = 0; i < prog_pc.size(); i++) begin
            if (prog_pc[i] == pc) begin
                return i;
            end
        end
        return -1;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // fetch model
    //////////////////////////////////////////////////////////////////////

    initial begin : drive_fetch
        addr_t       pc_next;
        int          idx;
        logic [31:0] rnd;
        fetch_i = '0;
        pc_next = '0;
        while (!run_done) begin
            @(posedge clk);
            rnd = next_random();
            if (reset_i) begin
                fetch_i <= '0;
                pc_next = '0;
            end else begin
                if (redirect_o.valid) begin
                    pc_next = redirect_o.addr;
                end
                idx = lookup_inst(pc_next);
                // roughly one cycle in four is a gap
                if (idx >= 0 && rnd[9:8] != 2'b00) begin
                    fetch_i.valid <= 1'b1;
                    fetch_i.pc    <= pc_next;
                    fetch_i.inst  <= prog_inst[idx];
                    pc_next = pc_next + 32'd4;
                end else begin
                    fetch_i.valid <= 1'b0;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input int idx, input string what,
                                   input logic [31:0] got, input logic [31:0] exp);
        mismatch_count++;
        $display("FAILED %0t: entry %0d %s got %h expected %h", $time, idx, what, got, exp);
    endtask

    task automatic wait_reset_done();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (reset_i && cycles < 20);
        if (reset_i) begin
            timeout_count++;
            $display("reset was never released");
        end
    endtask

    task automatic wait_retire(output logic seen);
        int cycles;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < RETIRE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (retire_o.valid) begin
                seen = 1'b1;
            end
        end
    endtask

    task automatic check_entry(input int idx);
        exp_t e;
        e = exp_q[idx];
        if (retire_o.pc !== e.pc) report_mismatch(idx, "retire pc", retire_o.pc, e.pc);
        if (retire_o.rd_wen !== e.rd_wen) report_mismatch(idx, "rd_wen", retire_o.rd_wen, e.rd_wen);
        if (retire_o.illegal !== e.illegal) report_mismatch(idx, "illegal", retire_o.illegal, e.illegal);
        if (e.rd_wen) begin
            if (retire_o.rd !== e.rd) report_mismatch(idx, "rd", retire_o.rd, e.rd);
            if (retire_o.wdata !== e.wdata) report_mismatch(idx, "wdata", retire_o.wdata, e.wdata);
        end
        if (redirect_o.valid !== e.taken) report_mismatch(idx, "redirect", redirect_o.valid, e.taken);
        if (e.taken && redirect_o.addr !== e.target) begin
            report_mismatch(idx, "redirect addr", redirect_o.addr, e.target);
        end
        if (brinfo_o.valid !== e.cti) report_mismatch(idx, "brinfo valid", brinfo_o.valid, e.cti);
        if (e.cti) begin
            if (brinfo_o.pc !== e.pc) report_mismatch(idx, "brinfo pc", brinfo_o.pc, e.pc);
            if (brinfo_o.is_jmp !== e.is_jmp) report_mismatch(idx, "is_jmp", brinfo_o.is_jmp, e.is_jmp);
            if (brinfo_o.is_br !== !e.is_jmp) report_mismatch(idx, "is_br", brinfo_o.is_br, !e.is_jmp);
            if (brinfo_o.taken !== e.taken) report_mismatch(idx, "taken", brinfo_o.taken, e.taken);
            if (brinfo_o.target !== e.target) report_mismatch(idx, "target", brinfo_o.target, e.target);
        end
    endtask

    initial begin : main_flow
        logic seen;
        load_tables();
        wait_reset_done();
        for (int i = 0; i < exp_q.size(); i++) begin
            wait_retire(seen);
            if (!seen) begin
                timeout_count++;
                $display("timeout: no retire for entry %0d at pc %h", i, exp_q[i].pc);
                break;
            end
            check_entry(i);
        end
        // wrong-path work must never show up after the last retire
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            if (retire_o.valid) report_mismatch(-1, "unexpected retire pc", retire_o.pc, 32'h0);
        end
        run_done = 1'b1;
        $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
